// ==== hdl/pe_num_pkg.sv ====
`default_nettype none

package pe_num_pkg;

    localparam int value_width = 8;
    localparam int coord_width = 8;
    localparam int count_width = 16;
    localparam int lanes = 4;

    typedef struct packed {
        logic signed [coord_width-1:0] row;
        logic signed [coord_width-1:0] col;
    } coord_t;

    typedef struct packed {
        logic signed [value_width-1:0] value;
        coord_t                        coord;
    } entry_t;

    typedef entry_t [lanes-1:0] entry_vec_t;

    // full-width product, offset of activation from weight
    typedef struct packed {
        logic signed [2*value_width-1:0] product;
        coord_t                          coord;
    } product_t;

    // indexed [weight slot][activation lane]
    typedef product_t [lanes-1:0][lanes-1:0] product_mat_t;

endpackage

`default_nettype wire

// ==== hdl/pe_ctrl_pkg.sv ====
`default_nettype none

package pe_ctrl_pkg;

    typedef enum logic [1:0] {
        idle        = 2'b00,
        load_weight = 2'b01,
        stream      = 2'b10,
        done        = 2'b11
    } pe_state_t;

    typedef logic [pe_num_pkg::count_width-1:0] count_t;

endpackage

`default_nettype wire

// ==== hdl/pe_controller.sv ====
`default_nettype none

module pe_controller (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  pe_ctrl_pkg::count_t   weight_total,
    input  pe_ctrl_pkg::count_t   feature_total,
    input  pe_ctrl_pkg::count_t   channel_in,
    output logic                  weight_we,
    output logic                  fire,
    output logic                  done,
    output logic [$clog2(pe_num_pkg::lanes)-1:0] weight_slot,
    output pe_ctrl_pkg::count_t   out_channel
);

    localparam int slot_width = $clog2(pe_num_pkg::lanes);
    localparam logic [slot_width-1:0] last_slot = slot_width'(pe_num_pkg::lanes - 1);
    localparam logic [pe_num_pkg::count_width:0] lane_round =
        (pe_num_pkg::count_width + 1)'(pe_num_pkg::lanes - 1);

    pe_ctrl_pkg::pe_state_t state;
    logic [slot_width-1:0]  slot_cnt;
    pe_ctrl_pkg::count_t    vec_cnt;
    pe_ctrl_pkg::count_t    grp_cnt;
    pe_ctrl_pkg::count_t    vec_last;
    pe_ctrl_pkg::count_t    grp_last;

    logic [pe_num_pkg::count_width:0] grp_sum;
    logic [pe_num_pkg::count_width:0] vec_sum;
    pe_ctrl_pkg::count_t    grp_last_start;
    pe_ctrl_pkg::count_t    vec_last_start;

    // ceil(total / lanes) - 1, taken at the start edge
    assign grp_sum = {1'b0, weight_total} + lane_round;
    assign vec_sum = {1'b0, feature_total} + lane_round;
    assign grp_last_start = pe_ctrl_pkg::count_t'((grp_sum >> slot_width) - 1'b1);
    assign vec_last_start = pe_ctrl_pkg::count_t'((vec_sum >> slot_width) - 1'b1);

    // start cycle in idle doubles as slot 0 load
    assign weight_we = in_valid &&
        (state == pe_ctrl_pkg::idle || state == pe_ctrl_pkg::load_weight);
    assign fire = in_valid && state == pe_ctrl_pkg::stream;
    assign weight_slot = slot_cnt;
    assign done = state == pe_ctrl_pkg::done;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= pe_ctrl_pkg::idle;
            slot_cnt    <= '0;
            vec_cnt     <= '0;
            grp_cnt     <= '0;
            vec_last    <= '0;
            grp_last    <= '0;
            out_channel <= '0;
        end else if (in_valid) begin
            case (state)
                pe_ctrl_pkg::idle: begin
                    grp_last    <= grp_last_start;
                    vec_last    <= vec_last_start;
                    out_channel <= channel_in;
                    slot_cnt    <= slot_cnt + 1'b1;
                    state       <= pe_ctrl_pkg::load_weight;
                end
                pe_ctrl_pkg::load_weight: begin
                    if (slot_cnt == last_slot) begin
                        slot_cnt <= '0;
                        state    <= pe_ctrl_pkg::stream;
                    end else begin
                        slot_cnt <= slot_cnt + 1'b1;
                    end
                end
                pe_ctrl_pkg::stream: begin
                    if (vec_cnt == vec_last) begin
                        vec_cnt <= '0;
                        if (grp_cnt == grp_last) begin
                            state <= pe_ctrl_pkg::done;
                        end else begin
                            grp_cnt <= grp_cnt + 1'b1;
                            state   <= pe_ctrl_pkg::load_weight;
                        end
                    end else begin
                        vec_cnt <= vec_cnt + 1'b1;
                    end
                end
                // held until reset
                default: begin
                    state <= pe_ctrl_pkg::done;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/weight_buffer.sv ====
`default_nettype none

module weight_buffer #(
    parameter int LANES = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     weight_we,
    input  logic [$clog2(LANES)-1:0] weight_slot,
    input  pe_num_pkg::entry_t       weight_in,
    output pe_num_pkg::entry_vec_t   weights
);

    // one register per slot, written only when addressed
    for (genvar i = 0; i < LANES; i++) begin : g_slot
        logic slot_we;

        assign slot_we = weight_we && weight_slot == ($clog2(LANES))'(i);

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                weights[i] <= '0;
            end else if (slot_we) begin
                weights[i] <= weight_in;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/outer_product_array.sv ====
`default_nettype none

module outer_product_array #(
    parameter int LANES = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     fire,
    input  pe_num_pkg::entry_vec_t   weights,
    input  pe_num_pkg::entry_vec_t   feature_in,
    output pe_num_pkg::product_mat_t products,
    output logic                     out_valid
);

    localparam int prod_width = 2 * pe_num_pkg::value_width;

    pe_num_pkg::product_mat_t result;

    for (genvar w = 0; w < LANES; w++) begin : g_weight
        for (genvar a = 0; a < LANES; a++) begin : g_act
            // signed 8x8 into 16 bits
            assign result[w][a].product =
                prod_width'($signed(weights[w].value)) *
                prod_width'($signed(feature_in[a].value));

            // output position is activation minus weight
            assign result[w][a].coord.row =
                $signed(feature_in[a].coord.row) - $signed(weights[w].coord.row);
            assign result[w][a].coord.col =
                $signed(feature_in[a].coord.col) - $signed(weights[w].coord.col);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= fire;
        end
    end

    // holds last result between fires
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            products <= '0;
        end else if (fire) begin
            products <= result;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sparse_pe_top.sv ====
`default_nettype none

module sparse_pe_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  pe_num_pkg::entry_t       weight_in,
    input  pe_num_pkg::entry_vec_t   feature_in,
    input  pe_ctrl_pkg::count_t      weight_total,
    input  pe_ctrl_pkg::count_t      feature_total,
    input  pe_ctrl_pkg::count_t      channel_in,
    output pe_num_pkg::product_mat_t products,
    output logic                     out_valid,
    output pe_ctrl_pkg::count_t      out_channel,
    output logic                     done
);

    localparam int LANES = pe_num_pkg::lanes;

    logic                     weight_we;
    logic                     fire;
    logic [$clog2(LANES)-1:0] weight_slot;
    pe_num_pkg::entry_vec_t   weights;

    pe_controller u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .weight_total  (weight_total),
        .feature_total (feature_total),
        .channel_in    (channel_in),
        .weight_we     (weight_we),
        .fire          (fire),
        .done          (done),
        .weight_slot   (weight_slot),
        .out_channel   (out_channel)
    );

    weight_buffer #(.LANES(LANES)) u_wbuf (
        .clk         (clk),
        .rst         (rst),
        .weight_we   (weight_we),
        .weight_slot (weight_slot),
        .weight_in   (weight_in),
        .weights     (weights)
    );

    outer_product_array #(.LANES(LANES)) u_array (
        .clk        (clk),
        .rst        (rst),
        .fire       (fire),
        .weights    (weights),
        .feature_in (feature_in),
        .products   (products),
        .out_valid  (out_valid)
    );

endmodule

`default_nettype wire

// ==== bench/clock_gen.sv ====
`default_nettype none

module clock_gen (
    input  logic reset_req,
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int reset_cycles = 4;

    logic [2:0] rst_cnt = 3'(reset_cycles);

    initial clk = 1'b0;

    // 20 ns period
    always #10 clk = ~clk;

    // reset held for four rising edges, restarted on request
    always @(posedge clk) begin
        if (reset_req) begin
            rst_cnt <= 3'(reset_cycles);
        end else if (rst_cnt != 3'd0) begin
            rst_cnt <= rst_cnt - 3'd1;
        end
    end

    assign rst = rst_cnt != 3'd0;

endmodule

`default_nettype wire

// ==== bench/pe_checker.sv ====
`default_nettype none

module pe_checker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     out_valid,
    input  logic                     done,
    input  pe_num_pkg::product_mat_t products,
    input  logic                     exp_push,
    input  pe_num_pkg::product_mat_t exp_mat,
    output int                       errors,
    output int                       results
);
    timeunit 1ns;
    timeprecision 1ps;

    pe_num_pkg::product_mat_t exp_q[$];
    logic done_prev = 1'b0;
    int   err_cnt = 0;
    int   res_cnt = 0;

    assign errors  = err_cnt;
    assign results = res_cnt;

    // DUT outputs are stable at the falling edge
    always @(negedge clk) begin : compare
        pe_num_pkg::product_mat_t want;
        if (!rst && out_valid) begin
            if (done_prev) begin
                $display("out_valid seen at %0t after done had already risen", $time);
                err_cnt++;
            end
            if (exp_q.size() == 0) begin
                $display("result at %0t with no vector outstanding", $time);
                err_cnt++;
            end else begin
                want = exp_q.pop_front();
                res_cnt++;
                for (int w = 0; w < pe_num_pkg::lanes; w++) begin
                    for (int a = 0; a < pe_num_pkg::lanes; a++) begin
                        if (products[w][a] !== want[w][a]) begin
                            $display("ERROR %0t products[%0d][%0d] got %h expected %h",
                                $time, w, a, products[w][a], want[w][a]);
                            err_cnt++;
                        end
                    end
                end
            end
        end
        done_prev = done;
        // vector accepted at the coming edge
        if (exp_push) begin
            exp_q.push_back(exp_mat);
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_top.sv ====
`default_nettype none

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int lanes = pe_num_pkg::lanes;
    localparam int wait_limit = 200;

    logic                     clk;
    logic                     rst;
    logic                     reset_req;
    logic                     in_valid;
    pe_num_pkg::entry_t       weight_in;
    pe_num_pkg::entry_vec_t   feature_in;
    pe_ctrl_pkg::count_t      weight_total;
    pe_ctrl_pkg::count_t      feature_total;
    pe_ctrl_pkg::count_t      channel_in;
    pe_num_pkg::product_mat_t products;
    logic                     out_valid;
    pe_ctrl_pkg::count_t      out_channel;
    logic                     done;
    logic                     exp_push;
    pe_num_pkg::product_mat_t exp_mat;
    int                       chk_errors;
    int                       chk_results;

    logic [31:0] words [512];
    logic [31:0] seed;
    int          ptr;
    int          tb_errors;
    int          jobs_run;
    logic        ok;

    clock_gen u_clk (.reset_req(reset_req), .clk(clk), .rst(rst));

    sparse_pe_top dut (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .weight_in     (weight_in),
        .feature_in    (feature_in),
        .weight_total  (weight_total),
        .feature_total (feature_total),
        .channel_in    (channel_in),
        .products      (products),
        .out_valid     (out_valid),
        .out_channel   (out_channel),
        .done          (done)
    );

    pe_checker u_check (
        .clk       (clk),
        .rst       (rst),
        .out_valid (out_valid),
        .done      (done),
        .products  (products),
        .exp_push  (exp_push),
        .exp_mat   (exp_mat),
        .errors    (chk_errors),
        .results   (chk_results)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        if (got !== want) begin
            $display("ERROR %0t %s got %h expected %h", $time, name, got, want);
            tb_errors++;
        end
    endtask

    // random stall cycles, then one accepted cycle at the next edge
    task automatic send(input pe_num_pkg::entry_t w, input pe_num_pkg::entry_vec_t f,
                        input logic push, input pe_num_pkg::product_mat_t e);
        int stalls;
        stalls = 0;
        @(posedge clk);
        seed = lcg_next(seed);
        while (seed[17:16] == 2'b00 && stalls < 6) begin
            in_valid <= 1'b0;
            exp_push <= 1'b0;
            stalls++;
            @(posedge clk);
            seed = lcg_next(seed);
        end
        in_valid   <= 1'b1;
        weight_in  <= w;
        feature_in <= f;
        exp_push   <= push;
        exp_mat    <= e;
    endtask

    task automatic reset_dut(output logic released);
        int n;
        @(posedge clk);
        reset_req <= 1'b1;
        @(posedge clk);
        reset_req <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (rst && n < wait_limit);
        released = !rst;
    endtask

    task automatic run_job(output logic finished);
        int groups;
        int vecs;
        int n;
        int err_start;
        int res_start;
        pe_num_pkg::entry_vec_t   f;
        pe_num_pkg::product_mat_t e;
        groups = (int'(words[ptr][15:0]) + lanes - 1) / lanes;
        vecs = (int'(words[ptr+1][15:0]) + lanes - 1) / lanes;
        err_start = tb_errors + chk_errors;
        res_start = chk_results;
        @(posedge clk);
        weight_total  <= words[ptr][15:0];
        feature_total <= words[ptr+1][15:0];
        channel_in    <= words[ptr+2][15:0];
        ptr += 3;
        for (int g = 0; g < groups; g++) begin
            for (int s = 0; s < lanes; s++) begin
                send(pe_num_pkg::entry_t'(words[ptr][23:0]), '0, 1'b0, '0);
                ptr++;
            end
            for (int v = 0; v < vecs; v++) begin
                for (int a = 0; a < lanes; a++) begin
                    f[a] = pe_num_pkg::entry_t'(words[ptr+a][23:0]);
                end
                ptr += lanes;
                for (int w = 0; w < lanes; w++) begin
                    for (int a = 0; a < lanes; a++) begin
                        e[w][a] = pe_num_pkg::product_t'(words[ptr + w*lanes + a]);
                    end
                end
                ptr += lanes * lanes;
                send('0, f, 1'b1, e);
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        exp_push <= 1'b0;
        n = 0;
        while (!done && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        finished = done;
        if (!done) begin
            $display("timeout: done did not rise for channel %h", channel_in);
        end else begin
            // room for the final result and any stray out_valid
            repeat (3) @(negedge clk);
            check_word("out_channel", {16'b0, out_channel}, {16'b0, channel_in});
            if (chk_results - res_start != groups * vecs) begin
                $display("expected %0d results but saw %0d", groups * vecs,
                    chk_results - res_start);
                tb_errors++;
            end
            $display("job channel %h: %0d groups, %0d vectors each, %0d errors",
                channel_in, groups, vecs, tb_errors + chk_errors - err_start);
        end
    endtask

    initial begin
        in_valid      = 1'b0;
        weight_in     = '0;
        feature_in    = '0;
        weight_total  = '0;
        feature_total = '0;
        channel_in    = '0;
        reset_req     = 1'b0;
        exp_push      = 1'b0;
        exp_mat       = '0;
        seed          = 32'ha31d;
        ptr           = 0;
        tb_errors     = 0;
        jobs_run      = 0;
        ok            = 1'b1;
        $readmemh("bench/pe_tests.txt", words);
        // one reset per job, zero header ends the list
        while (ok && words[ptr] !== 32'h0) begin
            reset_dut(ok);
            if (!ok) begin
                $display("timeout: reset was not released");
            end else begin
                check_word("out_valid", {31'b0, out_valid}, 32'h0);
                check_word("done", {31'b0, done}, 32'h0);
                check_word("out_channel", {16'b0, out_channel}, 32'h0);
                run_job(ok);
                jobs_run++;
            end
        end
        $display("jobs %0d, results checked %0d, errors %0d",
            jobs_run, chk_results, tb_errors + chk_errors);
        if (ok && tb_errors + chk_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/pe_tests.txt ====
// per job: weight_total feature_total channel, then per group four weights and per
// vector four activations plus sixteen expected products, weight slot major
// entries are {value,row,col}, products {product,row,col}; 0 0 0 ends the list
// single group, unit coordinates
0004 0004 0011
010000 020001 030100 040101
020101 030102 040201 050202
00020101 00030102 00040201 00050202 00040100 00060101 00080200 000a0201
00060001 00090002 000c0101 000f0102 00080000 000c0001 00100100 00140101
// signed values, negative offsets, padded last lane
0003 0003 0a5c
fd0203 05ff04 8000fe 000000
070000 ff01ff 80fd05 000000
ffebfefd 0003fffc 0180fb02 0000fefd 002301fc fffb02fb fd80fe01 000001fc
fc800002 00800101 4000fd07 00000002 00000000 000001ff 0000fd05 00000000
// two groups of two vectors
0008 0008 beef
010000 020000 030000 040000
010000 020001 030002 040003
00010000 00020001 00030002 00040003 00020000 00040001 00060002 00080003
00030000 00060001 00090002 000c0003 00040000 00080001 000c0002 00100003
050100 060101 070102 080103
00050100 00060101 00070102 00080103 000a0100 000c0101 000e0102 00100103
000f0100 00120101 00150102 00180103 00140100 00180101 001c0102 00200103
ff0101 fe0101 fd0101 fc0101
010101 020101 030101 040101
ffff0000 fffe0000 fffd0000 fffc0000 fffe0000 fffc0000 fffa0000 fff80000
fffd0000 fffa0000 fff70000 fff40000 fffc0000 fff80000 fff40000 fff00000
0a0000 0a0000 0a0000 0a0000
fff6ffff fff6ffff fff6ffff fff6ffff ffecffff ffecffff ffecffff ffecffff
ffe2ffff ffe2ffff ffe2ffff ffe2ffff ffd8ffff ffd8ffff ffd8ffff ffd8ffff
0 0 0

// ==== sparse_pe_top.f ====
hdl/pe_num_pkg.sv
hdl/pe_ctrl_pkg.sv
hdl/pe_controller.sv
hdl/weight_buffer.sv
hdl/outer_product_array.sv
hdl/sparse_pe_top.sv
bench/clock_gen.sv
bench/pe_checker.sv
bench/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_top
FILELIST  := sparse_pe_top.f
VFLAGS    := --binary --timing -j 0
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
